//--- include/desTables.svh
`ifndef DES_TABLES_SVH
`define DES_TABLES_SVH

// ================================================
// DES bit tables, 1-based with bit 1 as the MSB
// ================================================

localparam byte unsigned IP_TABLE [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2,  60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6,  64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9,  1,  59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5,  63, 55, 47, 39, 31, 23, 15, 7
};

// Inverse of IP
localparam byte unsigned FP_TABLE [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32,  39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30,  37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28,  35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26,  33, 1, 41, 9,  49, 17, 57, 25
};

// Drops the parity bits, C half first
localparam byte unsigned PC1_TABLE [56] = '{
    57, 49, 41, 33, 25, 17, 9,   1,  58, 50, 42, 34, 26, 18,
    10, 2,  59, 51, 43, 35, 27,  19, 11, 3,  60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7,  62, 54, 46, 38, 30, 22,
    14, 6,  61, 53, 45, 37, 29,  21, 13, 5,  28, 20, 12, 4
};

localparam byte unsigned PC2_TABLE [48] = '{
    14, 17, 11, 24, 1,  5,   3,  28, 15, 6,  21, 10,
    23, 19, 12, 4,  26, 8,   16, 7,  27, 20, 13, 2,
    41, 52, 31, 37, 47, 55,  30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53,  46, 42, 50, 36, 29, 32
};

localparam byte unsigned E_TABLE [48] = '{
    32, 1,  2,  3,  4,  5,   4,  5,  6,  7,  8,  9,
    8,  9,  10, 11, 12, 13,  12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21,  20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29,  28, 29, 30, 31, 32, 1
};

localparam byte unsigned P_TABLE [32] = '{
    16, 7,  20, 21, 29, 12, 28, 17,  1,  15, 23, 26, 5,  18, 31, 10,
    2,  8,  24, 14, 32, 27, 3,  9,   19, 13, 30, 6,  22, 11, 4,  25
};

// One 64-bit word per row, column 0 in the top nibble
localparam logic [63:0] SBOX_TABLE [8][4] = '{
    '{64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
      64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D},
    '{64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
      64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9},
    '{64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
      64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C},
    '{64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
      64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E},
    '{64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
      64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453},
    '{64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
      64'h9EF528C3704A1DB6, 64'h432C95FABE17608D},
    '{64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
      64'h14BDC37EAF680592, 64'h6BD814A7950FE23C},
    '{64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
      64'h7B419CE206ADF358, 64'h21E74A8DFC90356B}
};

`endif

//--- logic/desPkg.sv
package desPkg;

    localparam int BLOCK_WIDTH = 64;
    localparam int HALF_WIDTH = 32;
    localparam int CD_WIDTH = 28;
    localparam int SUBKEY_WIDTH = 48;
    localparam int ROUND_COUNT = 16;
    // Input stage plus one register per round
    localparam int PIPELINE_DEPTH = ROUND_COUNT + 1;
    localparam int WB_ADDR_WIDTH = 3;

    typedef logic [BLOCK_WIDTH-1:0] blockT;
    typedef logic [HALF_WIDTH-1:0] halfT;
    typedef logic [CD_WIDTH-1:0] cdT;
    typedef logic [SUBKEY_WIDTH-1:0] subkeyT;

    // ================================================
    // Register map, word addresses
    // ================================================
    localparam logic [WB_ADDR_WIDTH-1:0] KEY_HI_ADDR = 3'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] KEY_LO_ADDR = 3'd1;
    localparam logic [WB_ADDR_WIDTH-1:0] DATA_HI_ADDR = 3'd2;
    localparam logic [WB_ADDR_WIDTH-1:0] DATA_LO_ADDR = 3'd3;
    localparam logic [WB_ADDR_WIDTH-1:0] CONTROL_ADDR = 3'd4;
    localparam logic [WB_ADDR_WIDTH-1:0] STATUS_ADDR = 3'd5;
    localparam logic [WB_ADDR_WIDTH-1:0] RESULT_HI_ADDR = 3'd6;
    localparam logic [WB_ADDR_WIDTH-1:0] RESULT_LO_ADDR = 3'd7;

    // Left rotation of C and D per encryption round
    localparam int shiftSchedule [ROUND_COUNT] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    `include "desTables.svh"

    // ================================================
    // Permutations and the round function
    // ================================================
    function automatic blockT initialPermutation(input blockT data);
        blockT result;
        for (int i = 0; i < 64; i++)
            result[63 - i] = data[64 - IP_TABLE[i]];
        return result;
    endfunction

    function automatic blockT finalPermutation(input blockT data);
        blockT result;
        for (int i = 0; i < 64; i++)
            result[63 - i] = data[64 - FP_TABLE[i]];
        return result;
    endfunction

    // Returns {C, D}
    function automatic logic [2*CD_WIDTH-1:0] permutedChoice1(input blockT key);
        logic [2*CD_WIDTH-1:0] result;
        for (int i = 0; i < 56; i++)
            result[55 - i] = key[64 - PC1_TABLE[i]];
        return result;
    endfunction

    function automatic subkeyT permutedChoice2(input logic [2*CD_WIDTH-1:0] cd);
        subkeyT result;
        for (int i = 0; i < 48; i++)
            result[47 - i] = cd[56 - PC2_TABLE[i]];
        return result;
    endfunction

    function automatic subkeyT expand(input halfT r);
        subkeyT result;
        for (int i = 0; i < 48; i++)
            result[47 - i] = r[32 - E_TABLE[i]];
        return result;
    endfunction

    // Outer bits pick the row, inner four the column
    function automatic logic [3:0] sboxLookup(input int box, input logic [5:0] six);
        logic [1:0] row;
        logic [3:0] col;
        row = {six[5], six[0]};
        col = six[4:1];
        return SBOX_TABLE[box][row][63 - 4*col -: 4];
    endfunction

    function automatic halfT feistel(input halfT r, input subkeyT subkey);
        subkeyT mixed;
        halfT sOut;
        halfT result;
        mixed = expand(r) ^ subkey;
        for (int b = 0; b < 8; b++)
            sOut[31 - 4*b -: 4] = sboxLookup(b, mixed[47 - 6*b -: 6]);
        for (int i = 0; i < 32; i++)
            result[31 - i] = sOut[32 - P_TABLE[i]];
        return result;
    endfunction

endpackage

//--- logic/desRound.sv
`timescale 1ns/1ns

module desRound import desPkg::*; #(
    parameter int ROUND_INDEX = 1
) (
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic inDecrypt,
    input  halfT inLeft,
    input  halfT inRight,
    input  cdT   inC,
    input  cdT   inD,
    output logic outValid,
    output logic outDecrypt,
    output halfT outLeft,
    output halfT outRight,
    output cdT   outC,
    output cdT   outD
);

    // Decryption walks the schedule backwards, round 1 sees C16 = C0
    localparam int ENC_SHIFT = shiftSchedule[ROUND_INDEX - 1];
    localparam int DEC_INDEX = (ROUND_INDEX == 1) ? 0 : 17 - ROUND_INDEX;
    localparam int DEC_SHIFT = (ROUND_INDEX == 1) ? 0 : shiftSchedule[DEC_INDEX];

    cdT rotC;
    cdT rotD;
    subkeyT subkey;

    function automatic cdT rotate(input cdT value, input int amount, input logic right);
        if (right)
            return (value >> amount) | (value << (CD_WIDTH - amount));
        return (value << amount) | (value >> (CD_WIDTH - amount));
    endfunction

    assign rotC = inDecrypt ? rotate(inC, DEC_SHIFT, 1'b1) : rotate(inC, ENC_SHIFT, 1'b0);
    assign rotD = inDecrypt ? rotate(inD, DEC_SHIFT, 1'b1) : rotate(inD, ENC_SHIFT, 1'b0);
    assign subkey = permutedChoice2({rotC, rotD});

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            outValid <= 1'b0;
            outDecrypt <= 1'b0;
        end
        else
        begin
            outValid <= inValid;
            outDecrypt <= inDecrypt;
        end
    end

    // Feistel step, the key state moves along with the block
    always_ff @(posedge clk)
    begin
        outLeft <= inRight;
        outRight <= inLeft ^ feistel(inRight, subkey);
        outC <= rotC;
        outD <= rotD;
    end

endmodule

//--- logic/desPipeline.sv
`timescale 1ns/1ns

module desPipeline import desPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  startValid,
    input  logic  startDecrypt,
    input  blockT startBlock,
    input  blockT startKey,
    output logic  resultValid,
    output blockT resultBlock
);

    blockT ipBlock;
    logic [2*CD_WIDTH-1:0] pc1Key;

    logic inValid;
    logic inDecrypt;
    halfT inLeft;
    halfT inRight;
    cdT inC;
    cdT inD;

    // Stage 0 is the input register, stage r the output of round r
    wire stageValid [PIPELINE_DEPTH];
    wire stageDecrypt [PIPELINE_DEPTH];
    wire halfT stageLeft [PIPELINE_DEPTH];
    wire halfT stageRight [PIPELINE_DEPTH];
    wire cdT stageC [PIPELINE_DEPTH];
    wire cdT stageD [PIPELINE_DEPTH];

    assign ipBlock = initialPermutation(startBlock);
    assign pc1Key = permutedChoice1(startKey);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            inValid <= 1'b0;
            inDecrypt <= 1'b0;
        end
        else
        begin
            inValid <= startValid;
            inDecrypt <= startDecrypt;
        end
    end

    always_ff @(posedge clk)
    begin
        inLeft <= ipBlock[BLOCK_WIDTH-1:HALF_WIDTH];
        inRight <= ipBlock[HALF_WIDTH-1:0];
        inC <= pc1Key[2*CD_WIDTH-1:CD_WIDTH];
        inD <= pc1Key[CD_WIDTH-1:0];
    end

    assign stageValid[0] = inValid;
    assign stageDecrypt[0] = inDecrypt;
    assign stageLeft[0] = inLeft;
    assign stageRight[0] = inRight;
    assign stageC[0] = inC;
    assign stageD[0] = inD;

    for (genvar r = 1; r <= ROUND_COUNT; r++)
    begin : gRound
        desRound #(.ROUND_INDEX(r)) uRound (
            .clk        (clk),
            .rst        (rst),
            .inValid    (stageValid[r-1]),
            .inDecrypt  (stageDecrypt[r-1]),
            .inLeft     (stageLeft[r-1]),
            .inRight    (stageRight[r-1]),
            .inC        (stageC[r-1]),
            .inD        (stageD[r-1]),
            .outValid   (stageValid[r]),
            .outDecrypt (stageDecrypt[r]),
            .outLeft    (stageLeft[r]),
            .outRight   (stageRight[r]),
            .outC       (stageC[r]),
            .outD       (stageD[r])
        );
    end

    // Halves swap before the final permutation
    assign resultValid = stageValid[ROUND_COUNT];
    assign resultBlock = finalPermutation({stageRight[ROUND_COUNT], stageLeft[ROUND_COUNT]});

endmodule

//--- logic/desResultFifo.sv
`timescale 1ns/1ns

module desResultFifo import desPkg::*; #(
    parameter int RESULT_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  blockT pushBlock,
    input  logic  pop,
    output blockT head,
    output logic [$clog2(RESULT_DEPTH + 1)-1:0] count
);

    localparam int PTR_WIDTH = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;

    blockT mem [RESULT_DEPTH];
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH-1:0] rdPtr;

    // Wraps at the depth, which need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(RESULT_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (pop)
                rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wrPtr] <= pushBlock;
    end

    assign head = mem[rdPtr];

endmodule

//--- logic/desWbSlave.sv
`timescale 1ns/1ns

module desWbSlave import desPkg::*; #(
    parameter int RESULT_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cyc,
    input  logic  stb,
    input  logic  we,
    input  logic [WB_ADDR_WIDTH-1:0] adr,
    input  halfT  datWr,
    output halfT  datRd,
    output logic  ack,
    output logic  startValid,
    output logic  startDecrypt,
    output blockT startBlock,
    output blockT startKey,
    input  logic  resultValid,
    input  blockT fifoHead,
    input  logic [$clog2(RESULT_DEPTH + 1)-1:0] fifoCount,
    output logic  pop
);

    localparam int COUNT_WIDTH = $clog2(RESULT_DEPTH + 1);

    blockT keyReg;
    blockT dataReg;
    logic rejected;
    logic [COUNT_WIDTH-1:0] inFlight;
    logic [COUNT_WIDTH-1:0] outstanding;

    logic writeReq;
    logic startReq;
    logic accept;
    logic readAck;
    logic available;

    // ================================================
    // Bus decode
    // ================================================
    // Requests are acted on in the cycle before ack
    assign writeReq = cyc & stb & ~ack & we;
    assign startReq = writeReq && adr == CONTROL_ADDR && datWr[0];
    assign outstanding = inFlight + fifoCount;
    assign accept = startReq && outstanding < COUNT_WIDTH'(RESULT_DEPTH);
    assign readAck = ack & ~we;
    assign available = fifoCount != '0;
    assign pop = readAck && adr == RESULT_LO_ADDR && available;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ack <= 1'b0;
            startValid <= 1'b0;
            startDecrypt <= 1'b0;
            rejected <= 1'b0;
            inFlight <= '0;
        end
        else
        begin
            ack <= cyc & stb & ~ack;
            startValid <= accept;
            if (accept)
                startDecrypt <= datWr[1];
            // Sticky until software reads STATUS
            if (startReq && !accept)
                rejected <= 1'b1;
            else if (readAck && adr == STATUS_ADDR)
                rejected <= 1'b0;
            case ({accept, resultValid})
                2'b10:   inFlight <= inFlight + 1'b1;
                2'b01:   inFlight <= inFlight - 1'b1;
                default: inFlight <= inFlight;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (writeReq)
        begin
            case (adr)
                KEY_HI_ADDR:  keyReg[BLOCK_WIDTH-1:HALF_WIDTH] <= datWr;
                KEY_LO_ADDR:  keyReg[HALF_WIDTH-1:0] <= datWr;
                DATA_HI_ADDR: dataReg[BLOCK_WIDTH-1:HALF_WIDTH] <= datWr;
                DATA_LO_ADDR: dataReg[HALF_WIDTH-1:0] <= datWr;
                default:      ;
            endcase
        end
    end

    assign startKey = keyReg;
    assign startBlock = dataReg;

    // ================================================
    // Read path
    // ================================================
    always_comb
    begin
        case (adr)
            KEY_HI_ADDR:    datRd = keyReg[BLOCK_WIDTH-1:HALF_WIDTH];
            KEY_LO_ADDR:    datRd = keyReg[HALF_WIDTH-1:0];
            DATA_HI_ADDR:   datRd = dataReg[BLOCK_WIDTH-1:HALF_WIDTH];
            DATA_LO_ADDR:   datRd = dataReg[HALF_WIDTH-1:0];
            STATUS_ADDR:    datRd = {16'd0, 8'(fifoCount), 6'd0, rejected, available};
            // Empty queue reads as zero
            RESULT_HI_ADDR: datRd = available ? fifoHead[BLOCK_WIDTH-1:HALF_WIDTH] : '0;
            RESULT_LO_ADDR: datRd = available ? fifoHead[HALF_WIDTH-1:0] : '0;
            default:        datRd = '0;
        endcase
    end

endmodule

//--- logic/desWbTop.sv
`timescale 1ns/1ns

module desWbTop import desPkg::*; #(
    parameter int RESULT_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic cyc,
    input  logic stb,
    input  logic we,
    input  logic [WB_ADDR_WIDTH-1:0] adr,
    input  halfT datWr,
    input  logic [3:0] sel,
    output halfT datRd,
    output logic ack
);

    localparam int COUNT_WIDTH = $clog2(RESULT_DEPTH + 1);

    logic startValid;
    logic startDecrypt;
    blockT startBlock;
    blockT startKey;
    logic resultValid;
    blockT resultBlock;
    blockT fifoHead;
    logic [COUNT_WIDTH-1:0] fifoCount;
    logic pop;

    // Only full-word access, sel is not decoded
    desWbSlave #(.RESULT_DEPTH(RESULT_DEPTH)) uSlave (
        .clk          (clk),
        .rst          (rst),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .datWr        (datWr),
        .datRd        (datRd),
        .ack          (ack),
        .startValid   (startValid),
        .startDecrypt (startDecrypt),
        .startBlock   (startBlock),
        .startKey     (startKey),
        .resultValid  (resultValid),
        .fifoHead     (fifoHead),
        .fifoCount    (fifoCount),
        .pop          (pop)
    );

    desPipeline uPipeline (
        .clk          (clk),
        .rst          (rst),
        .startValid   (startValid),
        .startDecrypt (startDecrypt),
        .startBlock   (startBlock),
        .startKey     (startKey),
        .resultValid  (resultValid),
        .resultBlock  (resultBlock)
    );

    // Credit in the slave keeps this from overflowing
    desResultFifo #(.RESULT_DEPTH(RESULT_DEPTH)) uFifo (
        .clk       (clk),
        .rst       (rst),
        .push      (resultValid),
        .pushBlock (resultBlock),
        .pop       (pop),
        .head      (fifoHead),
        .count     (fifoCount)
    );

endmodule

//--- verification/desWb_checker.sv
`timescale 1ns/1ns

module desWb_checker import desPkg::*; #(
    parameter int RESULT_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic [$clog2(RESULT_DEPTH + 1)-1:0] outstanding
);

    // Ack only answers a live request
    ackNeedsRequest: assert property (@(posedge clk) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("ack asserted without cyc and stb");

    // Classic cycle, one ack per request
    ackSingleCycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack)
        else $error("ack held for more than one cycle");

    // Blocks in flight plus queued never pass the queue size
    creditLimit: assert property (@(posedge clk) disable iff (rst)
        outstanding <= RESULT_DEPTH)
        else $error("outstanding count above the queue capacity");

endmodule

bind desWbSlave desWb_checker #(.RESULT_DEPTH(RESULT_DEPTH)) uChecker (
    .clk         (clk),
    .rst         (rst),
    .cyc         (cyc),
    .stb         (stb),
    .ack         (ack),
    .outstanding (outstanding)
);

//--- verification/desWbTb.sv
`timescale 1ns/1ns

module desWbTb import desPkg::*; ();

    localparam int RESULT_DEPTH = 4;
    localparam int ACK_LIMIT = 16;
    localparam int POLL_LIMIT = 200;

    // Known-answer vectors
    localparam blockT KA_KEY [2] = '{64'h133457799BBCDFF1, 64'h0E329232EA6D0D73};
    localparam blockT KA_PLAIN [2] = '{64'h0123456789ABCDEF, 64'h8787878787878787};
    localparam blockT KA_CIPHER [2] = '{64'h85E813540F0AB405, 64'h0000000000000000};

    logic clk;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [WB_ADDR_WIDTH-1:0] adr;
    halfT datWr;
    logic [3:0] sel;
    halfT datRd;
    logic ack;

    int testErrors;
    int totalErrors;
    int testsRun;
    int testsFailed;

    desWbTop #(.RESULT_DEPTH(RESULT_DEPTH)) dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datWr (datWr),
        .sel   (sel),
        .datRd (datRd),
        .ack   (ack)
    );

    always #4 clk = ~clk;

    // ================================================
    // Bus access
    // ================================================
    task automatic abortRun(input string reason);
        $display("Timeout: %s", reason);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic wbTransfer(input logic write, input logic [WB_ADDR_WIDTH-1:0] addr,
                              input halfT wrData, output halfT rdData);
        int waitCycles;
        logic gotAck;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= write;
        adr <= addr;
        datWr <= wrData;
        @(posedge clk);
        waitCycles = 1;
        gotAck = ack;
        rdData = datRd;
        while (!gotAck && waitCycles < ACK_LIMIT)
        begin
            @(posedge clk);
            waitCycles++;
            gotAck = ack;
            rdData = datRd;
        end
        if (!gotAck)
            abortRun("no ack from the slave");
        else
        begin
            cyc <= 1'b0;
            stb <= 1'b0;
            we <= 1'b0;
        end
    endtask

    task automatic wbWrite(input logic [WB_ADDR_WIDTH-1:0] addr, input halfT data);
        halfT unused;
        wbTransfer(1'b1, addr, data, unused);
    endtask

    task automatic wbRead(input logic [WB_ADDR_WIDTH-1:0] addr, output halfT data);
        wbTransfer(1'b0, addr, '0, data);
    endtask

    task automatic issueStart(input blockT key, input blockT block, input logic decrypt);
        wbWrite(KEY_HI_ADDR, key[63:32]);
        wbWrite(KEY_LO_ADDR, key[31:0]);
        wbWrite(DATA_HI_ADDR, block[63:32]);
        wbWrite(DATA_LO_ADDR, block[31:0]);
        wbWrite(CONTROL_ADDR, {30'd0, decrypt, 1'b1});
    endtask

    // The low word read pops the queue
    task automatic readBlock(output blockT block);
        halfT hi;
        halfT lo;
        wbRead(RESULT_HI_ADDR, hi);
        wbRead(RESULT_LO_ADDR, lo);
        block = {hi, lo};
    endtask

    task automatic waitForCount(input int target);
        halfT status;
        int polls;
        polls = 0;
        wbRead(STATUS_ADDR, status);
        while (int'(status[15:8]) != target && polls < POLL_LIMIT)
        begin
            wbRead(STATUS_ADDR, status);
            polls++;
        end
        if (int'(status[15:8]) != target)
            abortRun("queue count never reached the expected level");
    endtask

    // Polls the result-available flag
    task automatic waitForResult();
        halfT status;
        int polls;
        polls = 0;
        wbRead(STATUS_ADDR, status);
        while (!status[0] && polls < POLL_LIMIT)
        begin
            wbRead(STATUS_ADDR, status);
            polls++;
        end
        if (!status[0])
            abortRun("no result became available");
    endtask

    task automatic runCipher(input blockT key, input blockT block, input logic decrypt,
                             output blockT result);
        issueStart(key, block, decrypt);
        waitForResult();
        readBlock(result);
    endtask

    // ================================================
    // Checking and reporting
    // ================================================
    task automatic compareValue(input string testName, input blockT expected,
                                input blockT actual);
        assert (actual === expected)
        else
        begin
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
            testErrors++;
        end
    endtask

    task automatic finishTest(input string testName);
        testsRun++;
        totalErrors += testErrors;
        if (testErrors == 0)
            $display("%s: passed", testName);
        else
        begin
            testsFailed++;
            $display("%s: %0d checks failed", testName, testErrors);
        end
        testErrors = 0;
    endtask

    // ================================================
    // Directed tests
    // ================================================
    task automatic testEmptyQueue();
        halfT data;
        wbRead(STATUS_ADDR, data);
        compareValue("emptyQueue", 64'd0, data);
        wbRead(RESULT_LO_ADDR, data);
        compareValue("emptyQueue", 64'd0, data);
        wbRead(STATUS_ADDR, data);
        compareValue("emptyQueue", 64'd0, data[15:8]);
        finishTest("emptyQueue");
    endtask

    task automatic testKnownAnswers(input logic decrypt);
        blockT result;
        string name;
        name = decrypt ? "knownDecrypt" : "knownEncrypt";
        for (int i = 0; i < 2; i++)
        begin
            runCipher(KA_KEY[i], decrypt ? KA_CIPHER[i] : KA_PLAIN[i], decrypt, result);
            compareValue(name, decrypt ? KA_PLAIN[i] : KA_CIPHER[i], result);
        end
        finishTest(name);
    endtask

    task automatic testRoundTrip();
        blockT key;
        blockT plain;
        blockT cipher;
        blockT back;
        for (int i = 0; i < 10; i++)
        begin
            key = {$urandom(), $urandom()};
            plain = {$urandom(), $urandom()};
            runCipher(key, plain, 1'b0, cipher);
            runCipher(key, cipher, 1'b1, back);
            compareValue("roundTrip", plain, back);
        end
        finishTest("roundTrip");
    endtask

    // Cases and modes alternate so each block needs its own key
    task automatic testBlocksInFlight();
        blockT expected [RESULT_DEPTH];
        blockT result;
        halfT status;
        int caseIdx;
        logic decrypt;
        for (int i = 0; i < RESULT_DEPTH; i++)
        begin
            caseIdx = i % 2;
            decrypt = ((i / 2) + i) % 2;
            expected[i] = decrypt ? KA_PLAIN[caseIdx] : KA_CIPHER[caseIdx];
            issueStart(KA_KEY[caseIdx], decrypt ? KA_CIPHER[caseIdx] : KA_PLAIN[caseIdx],
                       decrypt);
        end
        waitForCount(RESULT_DEPTH);
        for (int i = 0; i < RESULT_DEPTH; i++)
        begin
            readBlock(result);
            compareValue("blocksInFlight", expected[i], result);
        end
        wbRead(STATUS_ADDR, status);
        compareValue("blocksInFlight", 64'd0, status[15:8]);
        finishTest("blocksInFlight");
    endtask

    task automatic testBackPressure();
        halfT status;
        blockT result;
        for (int i = 0; i < RESULT_DEPTH; i++)
            issueStart(KA_KEY[0], KA_PLAIN[0], 1'b0);
        waitForCount(RESULT_DEPTH);
        issueStart(KA_KEY[0], KA_PLAIN[0], 1'b0);
        wbRead(STATUS_ADDR, status);
        compareValue("backPressure", 64'd1, status[0]);
        compareValue("backPressure", 64'd1, status[1]);
        compareValue("backPressure", RESULT_DEPTH, status[15:8]);
        // Rejected bit clears on read
        wbRead(STATUS_ADDR, status);
        compareValue("backPressure", 64'd0, status[1]);
        compareValue("backPressure", RESULT_DEPTH, status[15:8]);
        readBlock(result);
        compareValue("backPressure", KA_CIPHER[0], result);
        issueStart(KA_KEY[1], KA_PLAIN[1], 1'b0);
        wbRead(STATUS_ADDR, status);
        compareValue("backPressure", 64'd0, status[1]);
        waitForCount(RESULT_DEPTH);
        for (int i = 0; i < RESULT_DEPTH; i++)
        begin
            readBlock(result);
            compareValue("backPressure", (i == RESULT_DEPTH - 1) ? KA_CIPHER[1] : KA_CIPHER[0],
                         result);
        end
        wbRead(STATUS_ADDR, status);
        compareValue("backPressure", 64'd0, status[15:8]);
        finishTest("backPressure");
    endtask

    initial
    begin
        void'($urandom(32'h58aa7cd2));
        clk = 1'b0;
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        datWr = '0;
        sel = 4'hF;
        testErrors = 0;
        totalErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        testEmptyQueue();
        testKnownAnswers(1'b0);
        testKnownAnswers(1'b1);
        testRoundTrip();
        testBlocksInFlight();
        testBackPressure();

        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 testsRun, testsFailed, totalErrors);
        if (totalErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- desWbTop.f
+incdir+include
logic/desPkg.sv
logic/desRound.sv
logic/desPipeline.sv
logic/desResultFifo.sv
logic/desWbSlave.sv
logic/desWbTop.sv
verification/desWb_checker.sv
verification/desWbTb.sv
